/* common/rx_pkg.sv */
`default_nettype none

package rx_pkg;

    // --------------------------------------------------
    // data widths
    // --------------------------------------------------
    localparam int IQ_DW       = 32;
    localparam int IQ_HALF_DW  = IQ_DW / 2;
    localparam int PHASE_DW    = 20;
    localparam int CNT_DW      = 32;

    // component slots inside one sample word
    localparam int COMP_I = 0;
    localparam int COMP_Q = 1;

    // --------------------------------------------------
    // status register map
    // --------------------------------------------------
    localparam int REG_ADDR_DW = 3;
    localparam int REG_DW      = 32;

    localparam logic [REG_ADDR_DW-1:0] REG_ID          = 3'd0;
    localparam logic [REG_ADDR_DW-1:0] REG_LAST_SAMPLE = 3'd1;
    localparam logic [REG_ADDR_DW-1:0] REG_SAMPLE_CNT  = 3'd2;
    localparam logic [REG_ADDR_DW-1:0] REG_CFO_INC     = 3'd3;
    localparam logic [REG_ADDR_DW-1:0] REG_MODE        = 3'd4;

    localparam logic [REG_DW-1:0] DESIGN_ID = 32'h5253_0001;

    // one complex sample, Q in the upper half and I in the lower half
    typedef union packed {
        logic [IQ_DW-1:0]                raw;
        logic [1:0][IQ_HALF_DW-1:0]      comp;
    } iq_sample_t;

endpackage

`default_nettype wire

/* dv/tb_rx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rx_top;

    localparam int PHASE_DW = rx_pkg::PHASE_DW;
    localparam int TIMEOUT  = 20;

    localparam logic [PHASE_DW-1:0] QUARTER_TURN = 20'h40000;
    localparam logic [PHASE_DW-1:0] MINUS_QUARTER = 20'hC0000;
    localparam logic [PHASE_DW-1:0] MINUS_HALF = 20'h80000;

    logic                           clk_i;
    logic                           reset_ni;
    rx_pkg::iq_sample_t             sample_i;
    logic                           sample_valid_i;
    logic signed [PHASE_DW-1:0]     cfo_inc_i;
    logic                           cfo_inc_valid_i;
    logic                           cfo_manual_i;
    logic [rx_pkg::REG_ADDR_DW-1:0] rd_addr_i;
    logic                           rd_strobe_i;
    rx_pkg::iq_sample_t             derot_o;
    logic                           derot_valid_o;
    logic [rx_pkg::REG_DW-1:0]      rd_data_o;
    logic                           rd_valid_o;

    // reference model state
    logic [PHASE_DW-1:0]    model_inc;
    logic [PHASE_DW-1:0]    model_phase;
    logic [31:0]            model_cnt;
    logic [31:0]            model_last;
    logic                   model_manual;
    integer                 seed;

    rx_top #(
        .PHASE_DW (PHASE_DW)
    ) i_rx_top (
        .clk_i           (clk_i),
        .reset_ni        (reset_ni),
        .sample_i        (sample_i),
        .sample_valid_i  (sample_valid_i),
        .cfo_inc_i       (cfo_inc_i),
        .cfo_inc_valid_i (cfo_inc_valid_i),
        .cfo_manual_i    (cfo_manual_i),
        .rd_addr_i       (rd_addr_i),
        .rd_strobe_i     (rd_strobe_i),
        .derot_o         (derot_o),
        .derot_valid_o   (derot_valid_o),
        .rd_data_o       (rd_data_o),
        .rd_valid_o      (rd_valid_o)
    );

    always #50 clk_i = ~clk_i;

    // --------------------------------------------------
    // checks and waits
    // --------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH %s: actual 0x%h expected 0x%h", name, actual, expected);
            $display("Test FAILED");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s was never raised within %0d cycles", what, TIMEOUT);
        $display("Test FAILED");
        $fatal(1, "wait timed out");
    endtask

    task automatic wait_derot(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
        end while (!derot_valid_o && cycles < TIMEOUT);
        if (!derot_valid_o) begin
            report_timeout("derot_valid_o");
        end
    endtask

    task automatic wait_rd(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
        end while (!rd_valid_o && cycles < TIMEOUT);
        if (!rd_valid_o) begin
            report_timeout("rd_valid_o");
        end
    endtask

    // --------------------------------------------------
    // model
    // --------------------------------------------------
    function automatic logic [31:0] rotate_expected(input logic [31:0] raw,
                                                    input logic [PHASE_DW-1:0] ph);
        logic signed [15:0] i_in;
        logic signed [15:0] q_in;
        logic signed [15:0] i_out;
        logic signed [15:0] q_out;
        i_in = raw[15:0];
        q_in = raw[31:16];
        case (ph[PHASE_DW-1:PHASE_DW-2])
            2'd1: begin
                i_out = -q_in;
                q_out = i_in;
            end
            2'd2: begin
                i_out = -i_in;
                q_out = -q_in;
            end
            2'd3: begin
                i_out = q_in;
                q_out = -i_in;
            end
            default: begin
                i_out = i_in;
                q_out = q_in;
            end
        endcase
        return {q_out, i_out};
    endfunction

    // components within +-16383
    function automatic logic [31:0] random_sample();
        logic [15:0] i_part;
        logic [15:0] q_part;
        i_part = 16'($random(seed) % 16384);
        q_part = 16'($random(seed) % 16384);
        return {q_part, i_part};
    endfunction

    task automatic model_sample(input logic [31:0] raw, output logic [31:0] expected);
        expected = rotate_expected(raw, model_phase);
        if (!model_manual) begin
            model_phase = model_phase + model_inc;
        end
        model_cnt  = model_cnt + 32'd1;
        model_last = raw;
    endtask

    // --------------------------------------------------
    // bus tasks
    // --------------------------------------------------
    task automatic read_reg(input logic [2:0] addr, input logic [31:0] expected,
                            input string name);
        int cycles;
        @(posedge clk_i);
        #1;
        rd_addr_i   = addr;
        rd_strobe_i = 1'b1;
        @(posedge clk_i);
        #1;
        rd_strobe_i = 1'b0;
        wait_rd(cycles);
        check_value("rd_valid_o latency", cycles, 32'd1);
        check_value(name, rd_data_o, expected);
    endtask

    task automatic send_sample(input logic [31:0] raw);
        logic [31:0] expected;
        int cycles;
        model_sample(raw, expected);
        @(posedge clk_i);
        #1;
        sample_i.raw   = raw;
        sample_valid_i = 1'b1;
        @(posedge clk_i);
        #1;
        sample_valid_i = 1'b0;
        wait_derot(cycles);
        check_value("derot_valid_o latency", cycles, 32'd2);
        check_value("derot_o", derot_o.raw, expected);
    endtask

    task automatic set_cfo(input logic [PHASE_DW-1:0] value);
        @(posedge clk_i);
        #1;
        cfo_inc_i       = value;
        cfo_inc_valid_i = 1'b1;
        @(posedge clk_i);
        #1;
        cfo_inc_valid_i = 1'b0;
        if (!model_manual) begin
            // relative estimate
            model_inc = model_inc - value;
        end
        read_reg(rx_pkg::REG_CFO_INC, {{12{model_inc[PHASE_DW-1]}}, model_inc},
                 "rd_data_o REG_CFO_INC");
    endtask

    task automatic set_manual(input logic mode);
        @(posedge clk_i);
        #1;
        cfo_manual_i = mode;
        model_manual = mode;
        if (mode) begin
            model_inc   = '0;
            model_phase = '0;
        end
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic check_reset_state();
        read_reg(rx_pkg::REG_ID, 32'h5253_0001, "rd_data_o REG_ID");
        read_reg(rx_pkg::REG_SAMPLE_CNT, 32'd0, "rd_data_o REG_SAMPLE_CNT");
        read_reg(rx_pkg::REG_CFO_INC, 32'd0, "rd_data_o REG_CFO_INC");
        read_reg(rx_pkg::REG_MODE, 32'd0, "rd_data_o REG_MODE");
    endtask

    task automatic check_passthrough();
        int k;
        for (k = 0; k < 10; k++) begin
            send_sample(random_sample());
        end
        read_reg(rx_pkg::REG_SAMPLE_CNT, model_cnt, "rd_data_o REG_SAMPLE_CNT");
        read_reg(rx_pkg::REG_LAST_SAMPLE, model_last, "rd_data_o REG_LAST_SAMPLE");
        // unmapped address
        read_reg(3'd7, 32'd0, "rd_data_o unmapped address");
    endtask

    task automatic check_rotation();
        int k;
        set_cfo(MINUS_QUARTER);
        for (k = 0; k < 5; k++) begin
            send_sample(random_sample());
        end
        set_cfo(QUARTER_TURN);
        send_sample(random_sample());
        send_sample(random_sample());
    endtask

    task automatic send_burst(input int count);
        logic [31:0] raws [$];
        logic [31:0] exps [$];
        logic [31:0] raw;
        logic [31:0] expected;
        int k;
        int d;
        int c;
        int cycles;
        for (k = 0; k < count; k++) begin
            raw = random_sample();
            model_sample(raw, expected);
            raws.push_back(raw);
            exps.push_back(expected);
        end
        @(posedge clk_i);
        #1;
        fork
            begin
                for (d = 0; d < count; d++) begin
                    sample_i.raw   = raws[d];
                    sample_valid_i = 1'b1;
                    @(posedge clk_i);
                    #1;
                end
                sample_valid_i = 1'b0;
            end
            begin
                for (c = 0; c < count; c++) begin
                    wait_derot(cycles);
                    // first result shows on the third falling edge after the first drive
                    check_value("derot_valid_o spacing", cycles, (c == 0) ? 32'd3 : 32'd1);
                    check_value("derot_o", derot_o.raw, exps[c]);
                end
            end
        join
    endtask

    task automatic check_back_to_back();
        set_cfo(MINUS_HALF);
        send_burst(6);
        set_cfo(MINUS_HALF);
        set_cfo(MINUS_QUARTER);
        send_burst(8);
        read_reg(rx_pkg::REG_SAMPLE_CNT, model_cnt, "rd_data_o REG_SAMPLE_CNT");
    endtask

    task automatic check_manual_mode();
        int k;
        set_manual(1'b1);
        read_reg(rx_pkg::REG_MODE, 32'd1, "rd_data_o REG_MODE");
        set_cfo(20'h12345);
        for (k = 0; k < 3; k++) begin
            send_sample(random_sample());
        end
        set_manual(1'b0);
        read_reg(rx_pkg::REG_MODE, 32'd0, "rd_data_o REG_MODE");
        set_cfo(MINUS_QUARTER);
        for (k = 0; k < 4; k++) begin
            send_sample(random_sample());
        end
        read_reg(rx_pkg::REG_SAMPLE_CNT, model_cnt, "rd_data_o REG_SAMPLE_CNT");
        read_reg(rx_pkg::REG_LAST_SAMPLE, model_last, "rd_data_o REG_LAST_SAMPLE");
    endtask

    initial begin
        clk_i           = 1'b0;
        reset_ni        = 1'b0;
        sample_i.raw    = '0;
        sample_valid_i  = 1'b0;
        cfo_inc_i       = '0;
        cfo_inc_valid_i = 1'b0;
        cfo_manual_i    = 1'b0;
        rd_addr_i       = '0;
        rd_strobe_i     = 1'b0;
        seed            = 32'h9293;
        model_inc       = '0;
        model_phase     = '0;
        model_cnt       = '0;
        model_last      = '0;
        model_manual    = 1'b0;

        repeat (16) @(posedge clk_i);
        #1;
        reset_ni = 1'b1;

        check_reset_state();
        check_passthrough();
        check_rotation();
        check_back_to_back();
        check_manual_mode();

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/rx_frontend/cfo_phase_accum.sv */
`timescale 1ns/1ps
`default_nettype none

module cfo_phase_accum #(
    parameter int PHASE_DW = rx_pkg::PHASE_DW
) (
    input  logic                        clk_i,
    input  logic                        reset_ni,

    input  logic                        smp_valid_i,

    input  logic signed [PHASE_DW-1:0]  cfo_inc_i,
    input  logic                        cfo_inc_valid_i,
    input  logic                        cfo_manual_i,

    output logic [PHASE_DW-1:0]         phase_o,
    output logic signed [PHASE_DW-1:0]  cfo_inc_o,
    output logic                        cfo_manual_o
);

    logic signed [PHASE_DW-1:0]     cfo_inc_q;
    logic [PHASE_DW-1:0]            phase_q;
    logic                           cfo_manual_q;

    // --------------------------------------------------
    // increment and phase
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            cfo_inc_q    <= '0;
            phase_q      <= '0;
            cfo_manual_q <= 1'b0;
        end else begin
            cfo_manual_q <= cfo_manual_i;
            if (cfo_manual_i) begin
                // manual mode, no correction
                cfo_inc_q <= '0;
                phase_q   <= '0;
            end else begin
                // estimates are relative to the current increment
                if (cfo_inc_valid_i) begin
                    cfo_inc_q <= cfo_inc_q - cfo_inc_i;
                end
                // phase wraps, uses the increment held before this edge
                if (smp_valid_i) begin
                    phase_q <= phase_q + $unsigned(cfo_inc_q);
                end
            end
        end
    end

    assign phase_o      = phase_q;
    assign cfo_inc_o    = cfo_inc_q;
    assign cfo_manual_o = cfo_manual_q;

endmodule

`default_nettype wire

/* hw/rx_frontend/quadrant_derotator.sv */
`timescale 1ns/1ps
`default_nettype none

module quadrant_derotator #(
    parameter int PHASE_DW = rx_pkg::PHASE_DW
) (
    input  logic                    clk_i,
    input  logic                    reset_ni,

    input  rx_pkg::iq_sample_t      smp_data_i,
    input  logic                    smp_valid_i,
    input  logic [PHASE_DW-1:0]     phase_i,

    output rx_pkg::iq_sample_t      derot_o,
    output logic                    derot_valid_o
);

    localparam int HW = rx_pkg::IQ_HALF_DW;

    logic [1:0]             quadrant;
    logic signed [HW-1:0]   in_i;
    logic signed [HW-1:0]   in_q;
    logic signed [HW-1:0]   neg_i;
    logic signed [HW-1:0]   neg_q;
    logic signed [HW-1:0]   rot_i;
    logic signed [HW-1:0]   rot_q;
    rx_pkg::iq_sample_t     derot_q;
    logic                   derot_valid_q;

    assign quadrant = phase_i[PHASE_DW-1 -: 2];

    assign in_i  = $signed(smp_data_i.comp[rx_pkg::COMP_I]);
    assign in_q  = $signed(smp_data_i.comp[rx_pkg::COMP_Q]);
    // two's complement, -32768 stays -32768
    assign neg_i = -in_i;
    assign neg_q = -in_q;

    // --------------------------------------------------
    // rotation by n * 90 degrees
    // --------------------------------------------------
    always_comb begin
        case (quadrant)
            2'd1: begin
                rot_i = neg_q;
                rot_q = in_i;
            end
            2'd2: begin
                rot_i = neg_i;
                rot_q = neg_q;
            end
            2'd3: begin
                rot_i = in_q;
                rot_q = neg_i;
            end
            default: begin
                rot_i = in_i;
                rot_q = in_q;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (smp_valid_i) begin
            derot_q.comp[rx_pkg::COMP_I] <= rot_i;
            derot_q.comp[rx_pkg::COMP_Q] <= rot_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            derot_valid_q <= 1'b0;
        end else begin
            derot_valid_q <= smp_valid_i;
        end
    end

    assign derot_o       = derot_q;
    assign derot_valid_o = derot_valid_q;

endmodule

`default_nettype wire

/* hw/rx_frontend/sample_input.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_input (
    input  logic                        clk_i,
    input  logic                        reset_ni,

    input  rx_pkg::iq_sample_t          sample_i,
    input  logic                        sample_valid_i,

    output rx_pkg::iq_sample_t          smp_data_o,
    output logic                        smp_valid_o,
    output logic [rx_pkg::CNT_DW-1:0]   sample_cnt_o,
    output rx_pkg::iq_sample_t          last_sample_o
);

    rx_pkg::iq_sample_t             smp_data_q;
    logic                           smp_valid_q;
    logic [rx_pkg::CNT_DW-1:0]      sample_cnt_q;
    rx_pkg::iq_sample_t             last_sample_q;

    // sample stage towards the derotator
    always_ff @(posedge clk_i) begin
        smp_data_q.raw <= sample_i.raw;
    end

    // --------------------------------------------------
    // strobe, counter and status copy
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            smp_valid_q       <= 1'b0;
            sample_cnt_q      <= '0;
            last_sample_q.raw <= '0;
        end else begin
            smp_valid_q <= sample_valid_i;
            if (sample_valid_i) begin
                // counter wraps
                sample_cnt_q      <= sample_cnt_q + 1'b1;
                last_sample_q.raw <= sample_i.raw;
            end
        end
    end

    assign smp_data_o    = smp_data_q;
    assign smp_valid_o   = smp_valid_q;
    assign sample_cnt_o  = sample_cnt_q;
    assign last_sample_o = last_sample_q;

endmodule

`default_nettype wire

/* hw/rx_regmap.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_regmap (
    input  logic                                clk_i,
    input  logic                                reset_ni,

    input  logic [rx_pkg::REG_ADDR_DW-1:0]      rd_addr_i,
    input  logic                                rd_strobe_i,

    input  rx_pkg::iq_sample_t                  last_sample_i,
    input  logic [rx_pkg::CNT_DW-1:0]           sample_cnt_i,
    input  logic signed [rx_pkg::PHASE_DW-1:0]  cfo_inc_i,
    input  logic                                cfo_manual_i,

    output logic [rx_pkg::REG_DW-1:0]           rd_data_o,
    output logic                                rd_valid_o
);

    localparam int EXT_DW = rx_pkg::REG_DW - rx_pkg::PHASE_DW;

    logic [rx_pkg::REG_DW-1:0]  cfo_inc_ext;
    logic [rx_pkg::REG_DW-1:0]  mode_word;
    logic [rx_pkg::REG_DW-1:0]  rd_word;
    logic [rx_pkg::REG_DW-1:0]  rd_data_q;
    logic                       rd_valid_q;

    assign cfo_inc_ext = {{EXT_DW{cfo_inc_i[rx_pkg::PHASE_DW-1]}}, cfo_inc_i};
    assign mode_word   = {{(rx_pkg::REG_DW-1){1'b0}}, cfo_manual_i};

    // --------------------------------------------------
    // address decode
    // --------------------------------------------------
    always_comb begin
        case (rd_addr_i)
            rx_pkg::REG_ID: begin
                rd_word = rx_pkg::DESIGN_ID;
            end
            rx_pkg::REG_LAST_SAMPLE: begin
                rd_word = last_sample_i.raw;
            end
            rx_pkg::REG_SAMPLE_CNT: begin
                rd_word = sample_cnt_i;
            end
            rx_pkg::REG_CFO_INC: begin
                rd_word = cfo_inc_ext;
            end
            rx_pkg::REG_MODE: begin
                rd_word = mode_word;
            end
            default: begin
                rd_word = '0;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rd_strobe_i) begin
            rd_data_q <= rd_word;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rd_strobe_i;
        end
    end

    assign rd_data_o  = rd_data_q;
    assign rd_valid_o = rd_valid_q;

endmodule

`default_nettype wire

/* hw/rx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_top #(
    parameter int PHASE_DW = rx_pkg::PHASE_DW
) (
    input  logic                                clk_i,
    input  logic                                reset_ni,

    input  rx_pkg::iq_sample_t                  sample_i,
    input  logic                                sample_valid_i,

    input  logic signed [PHASE_DW-1:0]          cfo_inc_i,
    input  logic                                cfo_inc_valid_i,
    input  logic                                cfo_manual_i,

    input  logic [rx_pkg::REG_ADDR_DW-1:0]      rd_addr_i,
    input  logic                                rd_strobe_i,

    output rx_pkg::iq_sample_t                  derot_o,
    output logic                                derot_valid_o,

    output logic [rx_pkg::REG_DW-1:0]           rd_data_o,
    output logic                                rd_valid_o
);

    rx_pkg::iq_sample_t             smp_data;
    logic                           smp_valid;
    logic [rx_pkg::CNT_DW-1:0]      sample_cnt;
    rx_pkg::iq_sample_t             last_sample;
    logic [PHASE_DW-1:0]            phase;
    logic signed [PHASE_DW-1:0]     cfo_inc;
    logic                           cfo_manual_q;

    // --------------------------------------------------
    // sample path
    // --------------------------------------------------
    sample_input i_sample_input (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .smp_data_o     (smp_data),
        .smp_valid_o    (smp_valid),
        .sample_cnt_o   (sample_cnt),
        .last_sample_o  (last_sample)
    );

    cfo_phase_accum #(
        .PHASE_DW (PHASE_DW)
    ) i_cfo_phase_accum (
        .clk_i           (clk_i),
        .reset_ni        (reset_ni),
        .smp_valid_i     (smp_valid),
        .cfo_inc_i       (cfo_inc_i),
        .cfo_inc_valid_i (cfo_inc_valid_i),
        .cfo_manual_i    (cfo_manual_i),
        .phase_o         (phase),
        .cfo_inc_o       (cfo_inc),
        .cfo_manual_o    (cfo_manual_q)
    );

    quadrant_derotator #(
        .PHASE_DW (PHASE_DW)
    ) i_quadrant_derotator (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .smp_data_i    (smp_data),
        .smp_valid_i   (smp_valid),
        .phase_i       (phase),
        .derot_o       (derot_o),
        .derot_valid_o (derot_valid_o)
    );

    // status readback
    rx_regmap i_rx_regmap (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .rd_addr_i     (rd_addr_i),
        .rd_strobe_i   (rd_strobe_i),
        .last_sample_i (last_sample),
        .sample_cnt_i  (sample_cnt),
        .cfo_inc_i     (cfo_inc),
        .cfo_manual_i  (cfo_manual_q),
        .rd_data_o     (rd_data_o),
        .rd_valid_o    (rd_valid_o)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_rx_top \
    -Mdir obj_dir -o tb_rx_top

out=$(./obj_dir/tb_rx_top)
echo "$out"
echo "$out" | grep -q "Test OK"

/* vlog.f */
common/rx_pkg.sv
hw/rx_frontend/sample_input.sv
hw/rx_frontend/cfo_phase_accum.sv
hw/rx_frontend/quadrant_derotator.sv
hw/rx_regmap.sv
hw/rx_top.sv
dv/tb_rx_top.sv
